// ==== hw/video_pkg.sv ====
package video_pkg;

    // horizontal geometry in pixels
    localparam int H_VISIBLE = 32;
    localparam int H_FRONT   = 4;
    localparam int H_SYNC    = 4;
    localparam int H_BACK    = 8;
    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;   // 48

    // vertical geometry in lines
    localparam int V_VISIBLE = 8;
    localparam int V_FRONT   = 1;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 2;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;   // 13

    localparam int PIXELS_PER_WORD = 4;         // 4-bpp nibbles per vram word
    localparam int POINTER_SIZE    = 8;         // pointer is 8x8
    localparam int PIPE_DELAY      = 3;         // count to colour at the pins

    localparam logic [5:0] XR_VID_CTRL     = 6'h00;
    localparam logic [5:0] XR_SCANLINE     = 6'h02;
    localparam logic [5:0] XR_VID_LEFT     = 6'h03;
    localparam logic [5:0] XR_VID_RIGHT    = 6'h04;
    localparam logic [5:0] XR_POINTER_H    = 6'h05;
    localparam logic [5:0] XR_POINTER_V    = 6'h06;
    localparam logic [5:0] XR_PA_GFX_CTRL  = 6'h10;
    localparam logic [5:0] XR_PA_DISP_ADDR = 6'h12;
    localparam logic [5:0] XR_PA_LINE_LEN  = 6'h13;

    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  color_t;
    typedef logic [$clog2(H_TOTAL)-1:0] hres_t;
    typedef logic [$clog2(V_TOTAL)-1:0] vres_t;
    typedef logic [3:0]  pointer_addr_t;

    typedef struct packed {
        color_t      colorbase;                 // xor'd into every pixel
        logic        blank;
        logic [6:0]  reserved;
    } gfx_ctrl_t;

    typedef struct packed {
        logic [3:0]  color;                     // upper nibble of pointer pixels
        logic [11:0] pos_v;
    } pointer_v_t;

    // one register data word, viewed by register number
    typedef union packed {
        word_t       word;
        gfx_ctrl_t   gfx_ctrl;
        pointer_v_t  pointer_v;
    } xr_word_u;

    typedef struct packed {
        hres_t       h_count;
        vres_t       v_count;
        logic        h_visible;
        logic        v_visible;
        logic        end_of_line;
        logic        end_of_frame;
        logic        end_of_visible;            // last pixel of last visible line
    } raster_t;

    typedef struct packed {
        addr_t       start_addr;
        word_t       line_len;
        color_t      colorbase;
        logic        blank;
        color_t      border_color;
        hres_t       vid_left;
        hres_t       vid_right;
    } pf_cfg_t;

    typedef struct packed {
        hres_t       pos_h;
        logic [11:0] pos_v;
        logic [3:0]  color;
    } ptr_cfg_t;

endpackage

// ==== hw/video_timing.sv ====
module video_timing (
    input  logic                clk,
    input  logic                reset_i,
    output video_pkg::raster_t  raster_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o,
    output logic                h_blank_o,
    output logic                v_blank_o
);

    video_pkg::hres_t   h_count;
    video_pkg::vres_t   v_count;
    logic               h_visible;
    logic               v_visible;
    logic               end_of_line;
    logic               end_of_frame;
    logic               hsync;
    logic               vsync;
    logic [4:0]         vid_now;                            // hsync, vsync, de, h/v blank
    logic [video_pkg::PIPE_DELAY-1:0][4:0] vid_pipe;

    always_comb begin
        h_visible    = (h_count < video_pkg::hres_t'(video_pkg::H_VISIBLE));
        v_visible    = (v_count < video_pkg::vres_t'(video_pkg::V_VISIBLE));
        end_of_line  = (h_count == video_pkg::hres_t'(video_pkg::H_TOTAL - 1));
        end_of_frame = end_of_line && (v_count == video_pkg::vres_t'(video_pkg::V_TOTAL - 1));

        hsync = (h_count >= video_pkg::hres_t'(video_pkg::H_VISIBLE + video_pkg::H_FRONT)) &&
                (h_count < video_pkg::hres_t'(video_pkg::H_VISIBLE + video_pkg::H_FRONT +
                                               video_pkg::H_SYNC));
        vsync = (v_count >= video_pkg::vres_t'(video_pkg::V_VISIBLE + video_pkg::V_FRONT)) &&
                (v_count < video_pkg::vres_t'(video_pkg::V_VISIBLE + video_pkg::V_FRONT +
                                               video_pkg::V_SYNC));

        vid_now = {hsync, vsync, h_visible && v_visible, !h_visible, !v_visible};

        raster_o.h_count        = h_count;
        raster_o.v_count        = v_count;
        raster_o.h_visible      = h_visible;
        raster_o.v_visible      = v_visible;
        raster_o.end_of_line    = end_of_line;
        raster_o.end_of_frame   = end_of_frame;
        raster_o.end_of_visible = end_of_line &&
                                  (v_count == video_pkg::vres_t'(video_pkg::V_VISIBLE - 1));
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count  <= '0;
            v_count  <= '0;
            vid_pipe <= '0;
        end else begin
            if (end_of_line) begin
                h_count <= '0;
                v_count <= end_of_frame ? '0 : v_count + 1'b1;
            end else begin
                h_count <= h_count + 1'b1;
            end
            vid_pipe <= {vid_pipe[video_pkg::PIPE_DELAY-2:0], vid_now};    // match pixel path
        end
    end

    assign {hsync_o, vsync_o, dv_de_o, h_blank_o, v_blank_o} = vid_pipe[video_pkg::PIPE_DELAY-1];

endmodule

// ==== hw/video_regs.sv ====
module video_regs (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 reg_wr_en_i,
    input  logic [5:0]           reg_num_i,
    input  video_pkg::xr_word_u  reg_data_i,
    input  video_pkg::raster_t   raster_i,
    output video_pkg::word_t     reg_data_o,
    output video_pkg::pf_cfg_t   pf_cfg_o,
    output video_pkg::ptr_cfg_t  ptr_cfg_o,
    output logic                 intr_o
);

    video_pkg::xr_word_u rd_word;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pf_cfg_o.start_addr   <= '0;
            pf_cfg_o.line_len     <= video_pkg::word_t'(video_pkg::H_VISIBLE /
                                                        video_pkg::PIXELS_PER_WORD);
            pf_cfg_o.colorbase    <= '0;
            pf_cfg_o.blank        <= 1'b0;
            pf_cfg_o.border_color <= '0;
            pf_cfg_o.vid_left     <= '0;
            pf_cfg_o.vid_right    <= video_pkg::hres_t'(video_pkg::H_VISIBLE);
            ptr_cfg_o.pos_h       <= '0;
            ptr_cfg_o.pos_v       <= 12'(video_pkg::V_TOTAL);  // off the frame, pointer hidden
            ptr_cfg_o.color       <= '0;
            intr_o                <= 1'b0;
        end else begin
            intr_o <= raster_i.end_of_visible;                  // one pulse per frame

            if (reg_wr_en_i) begin
                case (reg_num_i)
                    video_pkg::XR_VID_CTRL: begin
                        pf_cfg_o.border_color <= reg_data_i.word[7:0];
                    end
                    video_pkg::XR_VID_LEFT: begin
                        pf_cfg_o.vid_left <= video_pkg::hres_t'(reg_data_i.word);
                    end
                    video_pkg::XR_VID_RIGHT: begin
                        pf_cfg_o.vid_right <= video_pkg::hres_t'(reg_data_i.word);
                    end
                    video_pkg::XR_POINTER_H: begin
                        ptr_cfg_o.pos_h <= video_pkg::hres_t'(reg_data_i.word);
                    end
                    video_pkg::XR_POINTER_V: begin
                        ptr_cfg_o.pos_v <= reg_data_i.pointer_v.pos_v;
                        ptr_cfg_o.color <= reg_data_i.pointer_v.color;
                    end
                    video_pkg::XR_PA_GFX_CTRL: begin
                        pf_cfg_o.colorbase <= reg_data_i.gfx_ctrl.colorbase;
                        pf_cfg_o.blank     <= reg_data_i.gfx_ctrl.blank;
                    end
                    video_pkg::XR_PA_DISP_ADDR: begin
                        pf_cfg_o.start_addr <= reg_data_i.word;
                    end
                    video_pkg::XR_PA_LINE_LEN: begin
                        pf_cfg_o.line_len <= reg_data_i.word;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // readback mux, pointer registers fall to zero
    always_comb begin
        rd_word.word = '0;
        case (reg_num_i)
            video_pkg::XR_VID_CTRL:     rd_word.word = video_pkg::word_t'(pf_cfg_o.border_color);
            video_pkg::XR_SCANLINE:     rd_word.word = video_pkg::word_t'(raster_i.v_count);
            video_pkg::XR_VID_LEFT:     rd_word.word = video_pkg::word_t'(pf_cfg_o.vid_left);
            video_pkg::XR_VID_RIGHT:    rd_word.word = video_pkg::word_t'(pf_cfg_o.vid_right);
            video_pkg::XR_PA_GFX_CTRL: begin
                rd_word.gfx_ctrl.colorbase = pf_cfg_o.colorbase;
                rd_word.gfx_ctrl.blank     = pf_cfg_o.blank;
            end
            video_pkg::XR_PA_DISP_ADDR: rd_word.word = pf_cfg_o.start_addr;
            video_pkg::XR_PA_LINE_LEN:  rd_word.word = pf_cfg_o.line_len;
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        reg_data_o <= rd_word.word;                             // one cycle after reg_num_i
    end

endmodule

// ==== hw/video_playfield.sv ====
module video_playfield (
    input  logic                 clk,
    input  logic                 reset_i,
    input  video_pkg::raster_t   raster_i,
    input  video_pkg::pf_cfg_t   cfg_i,
    input  video_pkg::word_t     vram_data_i,
    output logic                 vram_sel_o,
    output video_pkg::addr_t     vram_addr_o,
    output video_pkg::color_t    color_index_o
);

    video_pkg::addr_t  line_addr;                           // first word of current line
    video_pkg::addr_t  fetch_base;
    video_pkg::hres_t  fetch_x;                             // pixel that the fetch serves
    logic              fetch_wrap;
    logic              fetch_line_vis;
    logic              fetch;
    video_pkg::word_t  pix_word;                            // nibble shifter, high first
    video_pkg::hres_t  pix_x;
    logic              pix_vis;
    logic              in_window;
    logic [3:0]        nibble;

    // fetch runs two pixels ahead, sel register plus memory latency
    always_comb begin
        fetch_wrap = (raster_i.h_count >= video_pkg::hres_t'(video_pkg::H_TOTAL - 2));
        if (fetch_wrap) begin
            // first word of the next line
            fetch_x        = raster_i.h_count - video_pkg::hres_t'(video_pkg::H_TOTAL - 2);
            fetch_line_vis = (raster_i.v_count == video_pkg::vres_t'(video_pkg::V_TOTAL - 1)) ||
                             (raster_i.v_count < video_pkg::vres_t'(video_pkg::V_VISIBLE - 1));
            if (raster_i.v_count == video_pkg::vres_t'(video_pkg::V_TOTAL - 1)) begin
                fetch_base = cfg_i.start_addr;
            end else begin
                fetch_base = line_addr + cfg_i.line_len;
            end
        end else begin
            fetch_x        = raster_i.h_count + video_pkg::hres_t'(2);
            fetch_line_vis = raster_i.v_visible;
            fetch_base     = line_addr;
        end
        fetch = !cfg_i.blank && fetch_line_vis &&
                (fetch_x < video_pkg::hres_t'(video_pkg::H_VISIBLE)) &&
                ((fetch_x % video_pkg::PIXELS_PER_WORD) == 0);

        nibble    = cfg_i.blank ? 4'h0 : pix_word[15:12];
        in_window = pix_vis && (pix_x >= cfg_i.vid_left) && (pix_x < cfg_i.vid_right);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_addr     <= '0;
            vram_sel_o    <= 1'b0;
            color_index_o <= '0;
        end else begin
            if (raster_i.end_of_frame) begin
                line_addr <= cfg_i.start_addr;
            end else if (raster_i.end_of_line && raster_i.v_visible) begin
                line_addr <= line_addr + cfg_i.line_len;
            end
            vram_sel_o <= fetch;
            if (in_window) begin
                color_index_o <= video_pkg::color_t'(nibble) ^ cfg_i.colorbase;
            end else begin
                color_index_o <= cfg_i.border_color;            // border kept while blanked
            end
        end
    end

    always_ff @(posedge clk) begin
        vram_addr_o <= fetch_base + video_pkg::addr_t'(fetch_x / video_pkg::PIXELS_PER_WORD);
        if ((raster_i.h_count % video_pkg::PIXELS_PER_WORD) == 0) begin
            pix_word <= vram_data_i;                            // word fetched two cycles back
        end else begin
            pix_word <= {pix_word[11:0], 4'h0};
        end
        pix_x   <= raster_i.h_count;
        pix_vis <= raster_i.h_visible && raster_i.v_visible;
    end

endmodule

// ==== hw/video_pointer.sv ====
module video_pointer (
    input  logic                     clk,
    input  logic                     reset_i,
    input  video_pkg::raster_t       raster_i,
    input  video_pkg::ptr_cfg_t      cfg_i,
    input  video_pkg::color_t        pf_color_i,
    input  video_pkg::word_t         pointer_data_i,
    output video_pkg::pointer_addr_t pointer_addr_o,
    output video_pkg::color_t        color_index_o
);

    logic [$clog2(video_pkg::POINTER_SIZE):0] ptr_h;    // column, saturates at POINTER_SIZE
    logic [$clog2(video_pkg::POINTER_SIZE):0] ptr_v;    // row, saturates at POINTER_SIZE
    logic [1:0]  nib_sel;                               // column within fetched word
    logic        draw_d;
    logic [3:0]  nibble;

    // word for the next pixel, data returns as that pixel reaches us
    assign pointer_addr_o = video_pkg::pointer_addr_t'(
        ptr_v * (video_pkg::POINTER_SIZE / video_pkg::PIXELS_PER_WORD) +
        ptr_h / video_pkg::PIXELS_PER_WORD);

    assign nibble = pointer_data_i[4 * (3 - nib_sel) +: 4];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ptr_h         <= $bits(ptr_h)'(video_pkg::POINTER_SIZE);
            ptr_v         <= $bits(ptr_v)'(video_pkg::POINTER_SIZE);
            draw_d        <= 1'b0;
            color_index_o <= '0;
        end else begin
            if (raster_i.h_count == cfg_i.pos_h) begin
                ptr_h <= '0;
                if (12'(raster_i.v_count) == cfg_i.pos_v) begin
                    ptr_v <= '0;                        // top row
                end else if (ptr_v < video_pkg::POINTER_SIZE) begin
                    ptr_v <= ptr_v + 1'b1;
                end
            end else if (ptr_h < video_pkg::POINTER_SIZE) begin
                ptr_h <= ptr_h + 1'b1;
            end

            draw_d <= (ptr_h < video_pkg::POINTER_SIZE) && (ptr_v < video_pkg::POINTER_SIZE);

            if (draw_d && (nibble != 4'h0)) begin
                color_index_o <= {cfg_i.color, nibble};
            end else begin
                color_index_o <= pf_color_i;            // transparent pixel
            end
        end
    end

    always_ff @(posedge clk) begin
        nib_sel <= ptr_h[1:0];
    end

endmodule

// ==== hw/video_gen.sv ====
module video_gen (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     reg_wr_en_i,
    input  logic [5:0]               reg_num_i,
    input  video_pkg::word_t         reg_data_i,
    output video_pkg::word_t         reg_data_o,
    output logic                     video_intr_o,
    output logic                     vram_sel_o,
    output video_pkg::addr_t         vram_addr_o,
    input  video_pkg::word_t         vram_data_i,
    output video_pkg::pointer_addr_t pointer_addr_o,
    input  video_pkg::word_t         pointer_data_i,
    output video_pkg::color_t        color_index_o,
    output logic                     hsync_o,
    output logic                     vsync_o,
    output logic                     dv_de_o,
    output logic                     h_blank_o,
    output logic                     v_blank_o
);

    video_pkg::raster_t  raster;
    video_pkg::pf_cfg_t  pf_cfg;
    video_pkg::ptr_cfg_t ptr_cfg;
    video_pkg::color_t   pf_color;                  // playfield pixel before pointer

    video_timing u_timing (
        .clk        (clk),
        .reset_i    (reset_i),
        .raster_o   (raster),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o),
        .dv_de_o    (dv_de_o),
        .h_blank_o  (h_blank_o),
        .v_blank_o  (v_blank_o)
    );

    video_regs u_regs (
        .clk         (clk),
        .reset_i     (reset_i),
        .reg_wr_en_i (reg_wr_en_i),
        .reg_num_i   (reg_num_i),
        .reg_data_i  (reg_data_i),
        .raster_i    (raster),
        .reg_data_o  (reg_data_o),
        .pf_cfg_o    (pf_cfg),
        .ptr_cfg_o   (ptr_cfg),
        .intr_o      (video_intr_o)
    );

    video_playfield u_playfield (
        .clk           (clk),
        .reset_i       (reset_i),
        .raster_i      (raster),
        .cfg_i         (pf_cfg),
        .vram_data_i   (vram_data_i),
        .vram_sel_o    (vram_sel_o),
        .vram_addr_o   (vram_addr_o),
        .color_index_o (pf_color)
    );

    video_pointer u_pointer (
        .clk            (clk),
        .reset_i        (reset_i),
        .raster_i       (raster),
        .cfg_i          (ptr_cfg),
        .pf_color_i     (pf_color),
        .pointer_data_i (pointer_data_i),
        .pointer_addr_o (pointer_addr_o),
        .color_index_o  (color_index_o)
    );

endmodule

// ==== dv/video_gen_sva.sv ====
module video_gen_sva (
    input  logic clk,
    input  logic reset_i,
    input  logic hsync_i,
    input  logic intr_i,
    input  logic blank_i,
    input  logic vram_sel_i
);
    timeunit 1ns;
    timeprecision 1ps;

    property hsync_period;
        @(posedge clk) disable iff (reset_i)
            $rose(hsync_i) |-> ##(video_pkg::H_TOTAL) $rose(hsync_i);
    endproperty

    property intr_single_cycle;
        @(posedge clk) disable iff (reset_i)
            intr_i |=> !intr_i;
    endproperty

    // sel is registered, so blank takes effect one cycle later
    property no_fetch_when_blank;
        @(posedge clk) disable iff (reset_i)
            blank_i |=> !vram_sel_i;
    endproperty

    assert property (hsync_period)
        else $error("hsync_o rise-to-rise period differs from H_TOTAL");
    assert property (intr_single_cycle)
        else $error("video_intr_o held high for more than one cycle");
    assert property (no_fetch_when_blank)
        else $error("vram_sel_o asserted while the playfield is blanked");

endmodule

bind video_gen video_gen_sva u_sva (
    .clk        (clk),
    .reset_i    (reset_i),
    .hsync_i    (hsync_o),
    .intr_i     (video_intr_o),
    .blank_i    (pf_cfg.blank),
    .vram_sel_i (vram_sel_o)
);

// ==== dv/video_gen_tb.sv ====
module video_gen_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_CYCLES = video_pkg::H_TOTAL * video_pkg::V_TOTAL;

    typedef struct packed {
        logic [5:0]       num;
        video_pkg::word_t data;
        video_pkg::word_t expected;                     // readback after the write
    } reg_step_t;

    logic                     clk;
    logic                     reset_i;
    logic                     reg_wr_en_i;
    logic [5:0]               reg_num_i;
    video_pkg::word_t         reg_data_i;
    video_pkg::word_t         reg_data_o;
    logic                     video_intr_o;
    logic                     vram_sel_o;
    video_pkg::addr_t         vram_addr_o;
    video_pkg::word_t         vram_data_i;
    video_pkg::pointer_addr_t pointer_addr_o;
    video_pkg::word_t         pointer_data_i;
    video_pkg::color_t        color_index_o;
    logic                     hsync_o;
    logic                     vsync_o;
    logic                     dv_de_o;
    logic                     h_blank_o;
    logic                     v_blank_o;

    video_pkg::word_t vram [256];
    video_pkg::word_t ptr_mem [16];
    reg_step_t        steps [$];
    string            step_names [$];
    int               errors;
    int               checks;

    // expected register state kept from the writes
    video_pkg::color_t m_border;
    video_pkg::color_t m_colorbase;
    logic              m_blank;
    logic [3:0]        m_ptr_color;
    int                m_left;
    int                m_right;
    int                m_start;
    int                m_line_len;
    int                m_ptr_h;
    int                m_ptr_v;

    video_gen dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // both memories answer one cycle after the request
    always @(posedge clk) begin
        if (vram_sel_o) begin
            vram_data_i <= vram[vram_addr_o[7:0]];
        end
        pointer_data_i <= ptr_mem[pointer_addr_o];
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic video_pkg::color_t expected_pixel(input int x, input int y);
        video_pkg::word_t  data;
        video_pkg::color_t color;
        logic [3:0]        nib;
        int                col;
        int                row;
        col = x - m_ptr_h;
        row = y - m_ptr_v;
        if (x >= m_left && x < m_right) begin
            data  = vram[(m_start + y * m_line_len + x / video_pkg::PIXELS_PER_WORD) % 256];
            nib   = m_blank ? 4'h0 : data[4 * (3 - x % video_pkg::PIXELS_PER_WORD) +: 4];
            color = {4'h0, nib} ^ m_colorbase;
        end else begin
            color = m_border;
        end
        if (col >= 0 && col < video_pkg::POINTER_SIZE &&
            row >= 0 && row < video_pkg::POINTER_SIZE) begin
            data = ptr_mem[row * 2 + col / video_pkg::PIXELS_PER_WORD];
            nib  = data[4 * (3 - col % video_pkg::PIXELS_PER_WORD) +: 4];
            if (nib != 4'h0) begin
                color = {m_ptr_color, nib};             // opaque sprite pixel
            end
        end
        return color;
    endfunction

    task automatic add_step(input logic [5:0] num, input video_pkg::word_t data,
                            input video_pkg::word_t expected, input string name);
        reg_step_t step;
        step.num      = num;
        step.data     = data;
        step.expected = expected;
        steps.push_back(step);
        step_names.push_back(name);
    endtask

    task automatic compare(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        finish_run();
    endtask

    task automatic write_reg(input logic [5:0] num, input video_pkg::word_t data);
        @(posedge clk);
        reg_wr_en_i <= 1'b1;
        reg_num_i   <= num;
        reg_data_i  <= data;
        @(posedge clk);
        reg_wr_en_i <= 1'b0;
        case (num)
            video_pkg::XR_VID_CTRL:     m_border = data[7:0];
            video_pkg::XR_VID_LEFT:     m_left = data % 64;     // 6-bit pixel position
            video_pkg::XR_VID_RIGHT:    m_right = data % 64;
            video_pkg::XR_POINTER_H:    m_ptr_h = data % 64;
            video_pkg::XR_POINTER_V: begin
                m_ptr_v     = data[11:0];
                m_ptr_color = data[15:12];
            end
            video_pkg::XR_PA_GFX_CTRL: begin
                m_colorbase = data[15:8];
                m_blank     = data[7];
            end
            video_pkg::XR_PA_DISP_ADDR: m_start = data;
            video_pkg::XR_PA_LINE_LEN:  m_line_len = data;
            default: begin
            end
        endcase
    endtask

    task automatic wait_vsync_rise();
        int   cycles = 0;
        logic prev;
        @(negedge clk);
        prev = vsync_o;
        @(negedge clk);
        while (!(vsync_o && !prev)) begin
            cycles++;
            if (cycles > 2 * FRAME_CYCLES) begin
                report_timeout("vsync_o to rise");
            end
            prev = vsync_o;
            @(negedge clk);
        end
    endtask

    // runs one full frame from one vsync rise to the next
    task automatic check_frame(input string name);
        int   cycles = 0;
        int   x = 0;
        int   y = 0;
        int   hs_rises = 0;
        int   intr_high = 0;
        int   sel_rises = 0;
        int   h_active = 0;                             // cycles with h_blank_o low
        int   v_active = 0;                             // cycles with v_blank_o low
        logic prev_hs = hsync_o;
        logic prev_vs = vsync_o;
        logic prev_de = dv_de_o;
        logic prev_sel = vram_sel_o;
        logic frame_done = 1'b0;
        while (!frame_done) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2 * FRAME_CYCLES) begin
                report_timeout({"the end of frame ", name});
            end
            if (hsync_o && !prev_hs) hs_rises++;
            if (video_intr_o) intr_high++;
            if (vram_sel_o && !prev_sel) sel_rises++;
            if (!h_blank_o) h_active++;
            if (!v_blank_o) v_active++;
            if (dv_de_o) begin
                compare($sformatf("%s x%0d y%0d", name, x, y), expected_pixel(x, y),
                        color_index_o);
                x++;
            end else if (prev_de) begin
                compare({name, " pixels per line"}, video_pkg::H_VISIBLE, x);
                x = 0;
                y++;
            end
            frame_done = vsync_o && !prev_vs;
            prev_hs    = hsync_o;
            prev_vs    = vsync_o;
            prev_de    = dv_de_o;
            prev_sel   = vram_sel_o;
        end
        compare({name, " hsync pulses"}, video_pkg::V_TOTAL, hs_rises);
        compare({name, " visible lines"}, video_pkg::V_VISIBLE, y);
        compare({name, " interrupt cycles"}, 1, intr_high);
        compare({name, " h_blank_o low cycles"},
                video_pkg::H_VISIBLE * video_pkg::V_TOTAL, h_active);
        compare({name, " v_blank_o low cycles"},
                video_pkg::V_VISIBLE * video_pkg::H_TOTAL, v_active);
        if (m_blank) begin
            compare({name, " vram select rises"}, 0, sel_rises);
        end
    endtask

    initial begin
        logic [31:0] seed;
        errors         = 0;
        checks         = 0;
        reset_i        = 1'b1;
        reg_wr_en_i    = 1'b0;
        reg_num_i      = '0;
        reg_data_i     = '0;
        vram_data_i    = '0;
        pointer_data_i = '0;
        m_border       = '0;
        m_colorbase    = '0;
        m_blank        = 1'b0;
        m_ptr_color    = '0;
        m_left         = 0;
        m_right        = video_pkg::H_VISIBLE;
        m_start        = 0;
        m_line_len     = video_pkg::H_VISIBLE / video_pkg::PIXELS_PER_WORD;
        m_ptr_h        = 0;
        m_ptr_v        = video_pkg::V_TOTAL;

        seed = 32'ha05b;
        for (int i = 0; i < 256; i++) begin
            seed    = xorshift(seed);
            vram[i] = seed[15:0];
        end
        for (int i = 0; i < 16; i++) begin
            ptr_mem[i] = {4'(i), 4'h0, ~4'(i), 4'(i) ^ 4'h5};  // some nibbles transparent
        end

        add_step(video_pkg::XR_VID_CTRL,     16'h1234, 16'h0034, "border colour");
        add_step(video_pkg::XR_VID_LEFT,     16'hff84, 16'h0004, "window left");
        add_step(video_pkg::XR_VID_RIGHT,    16'h001c, 16'h001c, "window right");
        add_step(video_pkg::XR_POINTER_H,    16'h000a, 16'h0000, "pointer h");
        add_step(video_pkg::XR_POINTER_V,    16'h9002, 16'h0000, "pointer v");
        add_step(video_pkg::XR_PA_GFX_CTRL,  16'h507f, 16'h5000, "gfx ctrl");
        add_step(video_pkg::XR_PA_DISP_ADDR, 16'h0130, 16'h0130, "display address");
        add_step(video_pkg::XR_PA_LINE_LEN,  16'h000b, 16'h000b, "line length");
        add_step(6'h3f,                      16'hffff, 16'h0000, "unlisted register");

        repeat (10) @(posedge clk);
        reset_i <= 1'b0;

        foreach (steps[i]) begin
            write_reg(steps[i].num, steps[i].data);
            @(posedge clk);
            @(negedge clk);                             // readback is one cycle late
            compare(step_names[i], steps[i].expected, reg_data_o);
        end

        @(posedge clk);
        reg_num_i <= video_pkg::XR_SCANLINE;
        @(posedge clk);
        @(negedge clk);
        checks++;
        if (reg_data_o >= video_pkg::V_TOTAL) begin
            errors++;
            $display("CHECK FAILED scanline expected below %0d actual %0d",
                     video_pkg::V_TOTAL, reg_data_o);
        end

        wait_vsync_rise();
        check_frame("bitmap with pointer");

        // full window with the address wrapping past the end of the model memory
        write_reg(video_pkg::XR_VID_LEFT,     16'h0000);
        write_reg(video_pkg::XR_VID_RIGHT,    16'h0028);
        write_reg(video_pkg::XR_PA_DISP_ADDR, 16'h00f0);
        write_reg(video_pkg::XR_PA_LINE_LEN,  16'h000a);
        write_reg(video_pkg::XR_PA_GFX_CTRL,  16'h0f00);
        write_reg(video_pkg::XR_POINTER_H,    16'h001c);
        write_reg(video_pkg::XR_POINTER_V,    16'h3005);
        wait_vsync_rise();
        check_frame("wrapped bitmap");

        write_reg(video_pkg::XR_VID_LEFT,     16'h0004);
        write_reg(video_pkg::XR_VID_RIGHT,    16'h001c);
        write_reg(video_pkg::XR_PA_GFX_CTRL,  16'h5080);
        write_reg(video_pkg::XR_POINTER_V,    16'h000d);     // pointer off the frame
        wait_vsync_rise();
        check_frame("blanked");

        finish_run();
    end

endmodule

// ==== build.f ====
hw/video_pkg.sv
hw/video_timing.sv
hw/video_regs.sv
hw/video_playfield.sv
hw/video_pointer.sv
hw/video_gen.sv
dv/video_gen_sva.sv
dv/video_gen_tb.sv
